// ==== flist.f ====
src/nmi_pkg.sv
src/nmi_addr_decode.sv
src/nmi_gpio.sv
src/nmi_timer.sv
src/nmi_sysctrl.sv
src/nmi_rsp_merge.sv
src/nmi_periph_top.sv
verif/tb_clk_gen.sv
verif/tb_nmi_periph.sv

// ==== verif/tb_nmi_periph.sv ====
// nmi peripheral subsystem testbench
`timescale 1ns/1ns

module tb_nmi_periph;

  localparam int GPIO_W   = 16;
  localparam int TIM_W    = 16;
  localparam int SYS_WAIT = 2;
  localparam int N_RAND   = 12;
  localparam int P0       = 3;
  localparam int C0       = 4;
  localparam int P1       = 2;
  localparam int C1       = 3;
  localparam int TIM0_MAX = (P0 + 1) * (C0 + 1) + 2;
  // transfers in the sequence below at worst SYS_WAIT+3 cycles each
  localparam int N_XFER   = 12 * N_RAND + 8;
  localparam int LIMIT    = N_XFER * (SYS_WAIT + 3) + TIM0_MAX + 20;

  logic              clk;
  logic              rst_n;
  nmi_pkg::nmi_req_t req;
  nmi_pkg::nmi_rsp_t rsp;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic [7:0]        sys_ctrl;
  logic [1:0]        irq;

  // reference register file indexed by slot and word offset
  logic [31:0] m_reg[4][64];
  logic [31:0] lcg_state;
  int          issue_cnt;
  int          done_cnt;
  int          wait_cnt;
  int          exp_lat;
  logic        exp_rd;
  logic [31:0] exp_data;

  tb_clk_gen u_tb_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  nmi_periph_top #(
    .GPIO_W  (GPIO_W),
    .TIM_W   (TIM_W),
    .SYS_WAIT(SYS_WAIT)
  ) dut_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .nmi_req_i (req),
    .nmi_rsp_o (rsp),
    .gpio_in_i (gpio_in),
    .gpio_out_o(gpio_out),
    .gpio_oe_o (gpio_oe),
    .sys_ctrl_o(sys_ctrl),
    .irq_o     (irq)
  );

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [7:0] s, input logic [5:0] r);
    return {nmi_pkg::NATV_IP_START, 12'h000, s, r, 2'b00};
  endfunction

  // writable bits of each register
  function automatic logic [31:0] reg_mask(input logic [7:0] s, input logic [5:0] r);
    logic [31:0] gw;
    logic [31:0] tw;
    gw = 32'hffff_ffff >> (32 - GPIO_W);
    tw = 32'hffff_ffff >> (32 - TIM_W);
    case (s)
      nmi_pkg::SLOT_GPIO:    return (r < 6'd2) ? gw : '0;
      nmi_pkg::SLOT_SYSCTRL: return (r == 6'd1) ? '1 : ((r == 6'd2) ? 32'hff : '0);
      default:               return (r == 6'd0) ? 32'h3 : ((r < 6'd4) ? tw : '0);
    endcase
  endfunction

  function automatic void model_write(input logic [31:0] a, input logic [31:0] wd,
                                      input logic [3:0] st);
    logic [31:0] m;
    logic [7:0]  s;
    logic [5:0]  r;
    s = a[15:8];
    r = a[7:2];
    m = {{8{st[3]}}, {8{st[2]}}, {8{st[1]}}, {8{st[0]}}} & reg_mask(s, r);
    if (a[31:28] == nmi_pkg::NATV_IP_START && s < 8'd4) begin
      if ((s == nmi_pkg::SLOT_TIM0 || s == nmi_pkg::SLOT_TIM1) &&
          r == nmi_pkg::REG_TIM_STAT) begin
        // write one to clear
        m_reg[s][r] = (st[0] && wd[0]) ? 32'h0 : m_reg[s][r];
      end else begin
        m_reg[s][r] = (m_reg[s][r] & ~m) | (wd & m);
      end
    end
  endfunction

  function automatic logic [31:0] exp_read(input logic [31:0] a);
    if (a[31:28] != nmi_pkg::NATV_IP_START || a[15:8] > 8'd3) begin
      return '0;
    end
    return m_reg[a[15:8]][a[7:2]];
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      stop_run($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, want));
    end
  endtask

  // starts 1 ns after a rising edge and returns at the same phase
  task automatic xfer(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] st);
    exp_rd   = (st == 4'h0);
    exp_data = exp_read(a);
    exp_lat  = (a[31:28] == nmi_pkg::NATV_IP_START && a[15:8] == nmi_pkg::SLOT_SYSCTRL) ?
               SYS_WAIT + 1 : 1;
    issue_cnt++;
    req = '{valid: 1'b1, addr: a, wdata: wd, wstrb: st};
    wait (done_cnt == issue_cnt);
    if (!exp_rd) begin
      model_write(a, wd, st);
    end
    @(posedge clk);
    #1;
    req.valid = 1'b0;
  endtask

  // one ready per transfer checked mid-cycle
  always @(negedge clk) begin : compare
    if (rst_n && issue_cnt != done_cnt) begin
      if (rsp.ready) begin
        check_val("ready latency", 32'(wait_cnt), 32'(exp_lat));
        if (exp_rd) begin
          check_val("nmi_rsp_o.rdata", rsp.rdata, exp_data);
        end
        wait_cnt = 0;
        done_cnt++;
      end else begin
        wait_cnt++;
      end
    end else if (rst_n && rsp.ready) begin
      stop_run("A ready pulse arrived while no transfer was pending");
    end
  end

  initial begin : watchdog
    repeat (LIMIT) @(posedge clk);
    stop_run("Timeout: the test sequence did not finish in the expected number of cycles");
  end

  initial begin : main_seq
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  st;
    int          n;
    req       = '0;
    gpio_in   = '0;
    lcg_state = 32'd31129;
    issue_cnt = 0;
    done_cnt  = 0;
    wait_cnt  = 0;
    for (int s = 0; s < 4; s++) begin
      for (int r = 0; r < 64; r++) begin
        m_reg[s][r] = '0;
      end
    end
    m_reg[3][0] = nmi_pkg::SYS_ID;
    wait (rst_n);
    @(posedge clk);
    #1;
    check_val("nmi_rsp_o.ready", 32'(rsp.ready), 32'h0);
    check_val("irq_o", 32'(irq), 32'h0);
    check_val("gpio_out_o", 32'(gpio_out), 32'h0);
    check_val("gpio_oe_o", 32'(gpio_oe), 32'h0);
    check_val("sys_ctrl_o", 32'(sys_ctrl), 32'h0);

    // gpio out and oe with random byte strobes
    for (int i = 0; i < N_RAND; i++) begin
      d  = rand_word();
      st = (d[3:0] == 4'h0) ? 4'h1 : d[3:0];
      a  = reg_addr(nmi_pkg::SLOT_GPIO, 6'(i % 2));
      xfer(a, rand_word(), st);
      check_val("gpio_out_o", 32'(gpio_out), m_reg[0][0]);
      check_val("gpio_oe_o", 32'(gpio_oe), m_reg[0][1]);
      xfer(a, '0, 4'h0);
    end
    for (int i = 0; i < 3; i++) begin
      d           = rand_word();
      gpio_in     = d[GPIO_W-1:0];
      m_reg[0][2] = 32'(gpio_in);
      repeat (2) begin
        @(posedge clk);
        #1;
      end
      xfer(reg_addr(nmi_pkg::SLOT_GPIO, nmi_pkg::REG_GPIO_IN), '0, 4'h0);
    end

    // system control with a read-only ID register
    xfer(reg_addr(nmi_pkg::SLOT_SYSCTRL, nmi_pkg::REG_SYS_ID), rand_word(), 4'hf);
    xfer(reg_addr(nmi_pkg::SLOT_SYSCTRL, nmi_pkg::REG_SYS_ID), '0, 4'h0);
    for (int i = 0; i < N_RAND; i++) begin
      d  = rand_word();
      st = (d[3:0] == 4'h0) ? 4'h8 : d[3:0];
      a  = reg_addr(nmi_pkg::SLOT_SYSCTRL, (i % 2 == 1) ? nmi_pkg::REG_SYS_CTRL :
                    nmi_pkg::REG_SYS_SCRATCH);
      xfer(a, rand_word(), st);
      check_val("sys_ctrl_o", 32'(sys_ctrl), m_reg[3][2]);
      xfer(a, '0, 4'h0);
    end

    // count register readback and clear to zero
    for (int t = 1; t < 3; t++) begin
      a = reg_addr(8'(t), nmi_pkg::REG_TIM_CNT);
      xfer(a, rand_word(), 4'hf);
      xfer(a, '0, 4'h0);
      xfer(a, '0, 4'hf);
    end

    // timer 1 runs with irq masked while timer 0 has irq enabled
    xfer(reg_addr(nmi_pkg::SLOT_TIM1, nmi_pkg::REG_TIM_PSC), 32'(P1), 4'hf);
    xfer(reg_addr(nmi_pkg::SLOT_TIM1, nmi_pkg::REG_TIM_CMP), 32'(C1), 4'hf);
    xfer(reg_addr(nmi_pkg::SLOT_TIM1, nmi_pkg::REG_TIM_CTRL), 32'h1, 4'hf);
    xfer(reg_addr(nmi_pkg::SLOT_TIM0, nmi_pkg::REG_TIM_PSC), 32'(P0), 4'hf);
    xfer(reg_addr(nmi_pkg::SLOT_TIM0, nmi_pkg::REG_TIM_CMP), 32'(C0), 4'hf);
    xfer(reg_addr(nmi_pkg::SLOT_TIM0, nmi_pkg::REG_TIM_CTRL), 32'h3, 4'hf);
    n = 0;
    do begin
      @(negedge clk);
      n++;
      check_val("irq_o[1]", 32'(irq[1]), 32'h0);
      if (n > TIM0_MAX) begin
        stop_run("Timer 0 did not raise its interrupt within the compare period");
      end
    end while (!irq[0]);
    @(posedge clk);
    #1;
    m_reg[1][nmi_pkg::REG_TIM_STAT] = 32'h1;
    m_reg[2][nmi_pkg::REG_TIM_STAT] = 32'h1;
    // timer 1 stat was already set, so its irq follows the enable
    xfer(reg_addr(nmi_pkg::SLOT_TIM1, nmi_pkg::REG_TIM_CTRL), 32'h3, 4'hf);
    check_val("irq_o", 32'(irq), 32'h3);
    for (int t = 1; t < 3; t++) begin
      a = reg_addr(8'(t), nmi_pkg::REG_TIM_STAT);
      xfer(reg_addr(8'(t), nmi_pkg::REG_TIM_CTRL), 32'h2, 4'hf);
      xfer(a, '0, 4'h0);
      xfer(a, 32'h1, 4'hf);
      check_val("irq_o", 32'(irq[t-1]), 32'h0);
      xfer(a, '0, 4'h0);
    end

    // unmapped region or unused slot
    for (int i = 0; i < N_RAND; i++) begin
      d = rand_word();
      if (i % 2 == 1) begin
        a = {nmi_pkg::NATV_IP_START, d[27:16], d[15:8] | 8'h04, d[7:0]};
      end else begin
        a = {d[31:28] | 4'h2, d[27:0]};
      end
      xfer(a, rand_word(), 4'hf);
      xfer(a, '0, 4'h0);
    end
    xfer(reg_addr(nmi_pkg::SLOT_GPIO, nmi_pkg::REG_GPIO_OUT), '0, 4'h0);
    xfer(reg_addr(nmi_pkg::SLOT_GPIO, nmi_pkg::REG_GPIO_OE), '0, 4'h0);
    xfer(reg_addr(nmi_pkg::SLOT_SYSCTRL, nmi_pkg::REG_SYS_SCRATCH), '0, 4'h0);
    xfer(reg_addr(nmi_pkg::SLOT_SYSCTRL, nmi_pkg::REG_SYS_CTRL), '0, 4'h0);
    xfer(reg_addr(nmi_pkg::SLOT_TIM0, nmi_pkg::REG_TIM_PSC), '0, 4'h0);
    xfer(reg_addr(nmi_pkg::SLOT_TIM1, nmi_pkg::REG_TIM_CMP), '0, 4'h0);

    // back-to-back transfers alternating between slaves
    for (int i = 0; i < N_RAND; i++) begin
      xfer(reg_addr(nmi_pkg::SLOT_GPIO, 6'(i % 2)), '0, 4'h0);
      xfer(reg_addr(nmi_pkg::SLOT_SYSCTRL, 6'(i % 3)), '0, 4'h0);
      xfer(reg_addr(8'(1 + i % 2), 6'(i % 3)), '0, 4'h0);
      xfer(reg_addr(8'h10, 6'(i % 3)), '0, 4'h0);
    end

    repeat (2) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verif/tb_clk_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset low for four rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== src/nmi_periph_top.sv ====
// nmi peripheral subsystem
`timescale 1ns/1ns

module nmi_periph_top #(
  parameter int GPIO_W   = 16,
  parameter int TIM_W    = 16,
  parameter int SYS_WAIT = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t nmi_req_i,
  output nmi_pkg::nmi_rsp_t nmi_rsp_o,
  input  logic [GPIO_W-1:0] gpio_in_i,
  output logic [GPIO_W-1:0] gpio_out_o,
  output logic [GPIO_W-1:0] gpio_oe_o,
  output logic [7:0]        sys_ctrl_o,
  output logic [1:0]        irq_o
);

  logic [nmi_pkg::NUM_SLV-1:0] s_sel;
  logic                        s_miss;
  nmi_pkg::nmi_req_t           s_req[nmi_pkg::NUM_SLV];
  nmi_pkg::nmi_rsp_t           s_rsp[nmi_pkg::NUM_SLV];

  nmi_addr_decode u_nmi_addr_decode (
    .req_i (nmi_req_i),
    .sel_o (s_sel),
    .miss_o(s_miss)
  );

  // per-slave request, valid gated by its select
  for (genvar i = 0; i < nmi_pkg::NUM_SLV; i++) begin : g_req
    assign s_req[i] = '{
      valid: nmi_req_i.valid & s_sel[i],
      addr:  nmi_req_i.addr,
      wdata: nmi_req_i.wdata,
      wstrb: nmi_req_i.wstrb
    };
  end

  nmi_gpio #(
    .GPIO_W(GPIO_W)
  ) u_nmi_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (s_req[nmi_pkg::SEL_GPIO]),
    .rsp_o     (s_rsp[nmi_pkg::SEL_GPIO]),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  nmi_timer #(
    .TIM_W(TIM_W)
  ) u_nmi_timer0 (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (s_req[nmi_pkg::SEL_TIM0]),
    .rsp_o  (s_rsp[nmi_pkg::SEL_TIM0]),
    .irq_o  (irq_o[0])
  );

  nmi_timer #(
    .TIM_W(TIM_W)
  ) u_nmi_timer1 (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (s_req[nmi_pkg::SEL_TIM1]),
    .rsp_o  (s_rsp[nmi_pkg::SEL_TIM1]),
    .irq_o  (irq_o[1])
  );

  nmi_sysctrl #(
    .SYS_WAIT(SYS_WAIT)
  ) u_nmi_sysctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (s_req[nmi_pkg::SEL_SYSCTRL]),
    .rsp_o     (s_rsp[nmi_pkg::SEL_SYSCTRL]),
    .sys_ctrl_o(sys_ctrl_o)
  );

  nmi_rsp_merge u_nmi_rsp_merge (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rsp_i  (s_rsp),
    .miss_i (s_miss),
    .rsp_o  (nmi_rsp_o)
  );

endmodule

// ==== src/nmi_rsp_merge.sv ====
// nmi response merger
`timescale 1ns/1ns

module nmi_rsp_merge (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_rsp_t rsp_i[nmi_pkg::NUM_SLV],
  input  logic              miss_i,
  output nmi_pkg::nmi_rsp_t rsp_o
);

  logic miss_rdy_q;

  // unmapped access gets a one-cycle ready
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      miss_rdy_q <= 1'b0;
    end else begin
      miss_rdy_q <= miss_i && !miss_rdy_q;
    end
  end

  // only the answering slave contributes read data
  always_comb begin
    rsp_o.ready = miss_rdy_q;
    rsp_o.rdata = '0;
    for (int i = 0; i < nmi_pkg::NUM_SLV; i++) begin
      rsp_o.ready = rsp_o.ready | rsp_i[i].ready;
      rsp_o.rdata = rsp_o.rdata | ({32{rsp_i[i].ready}} & rsp_i[i].rdata);
    end
  end

endmodule

// ==== src/nmi_sysctrl.sv ====
// nmi system control block
`timescale 1ns/1ns

module nmi_sysctrl #(
  parameter int SYS_WAIT = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t rsp_o,
  output logic [7:0]        sys_ctrl_o
);

  logic        ready_q;
  logic [3:0]  wait_q;
  logic        accept;
  logic        wr_en;
  logic [5:0]  idx;
  logic [31:0] rd_val;
  logic [31:0] wr_val;
  logic [31:0] scratch_q;
  logic [7:0]  ctrl_q;

  assign idx = req_i.addr[7:2];
  // access completes once the wait count is used up
  assign accept = req_i.valid && !ready_q && (wait_q == 4'(SYS_WAIT));
  assign wr_en  = accept && (req_i.wstrb != 4'b0000);

  always_comb begin
    case (idx)
      nmi_pkg::REG_SYS_ID:      rd_val = nmi_pkg::SYS_ID;
      nmi_pkg::REG_SYS_SCRATCH: rd_val = scratch_q;
      nmi_pkg::REG_SYS_CTRL:    rd_val = 32'(ctrl_q);
      default:                  rd_val = '0;
    endcase
  end

  assign wr_val = nmi_pkg::strb_merge(rd_val, req_i.wdata, req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q   <= 1'b0;
      wait_q    <= '0;
      scratch_q <= '0;
      ctrl_q    <= '0;
    end else begin
      ready_q <= accept;
      if (!req_i.valid || ready_q) begin
        wait_q <= '0;
      end else if (!accept) begin
        wait_q <= wait_q + 1'b1;
      end
      if (wr_en && idx == nmi_pkg::REG_SYS_SCRATCH) begin
        scratch_q <= wr_val;
      end
      if (wr_en && idx == nmi_pkg::REG_SYS_CTRL) begin
        ctrl_q <= wr_val[7:0];
      end
    end
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = ready_q ? rd_val : '0;
  assign sys_ctrl_o  = ctrl_q;

endmodule

// ==== src/nmi_timer.sv ====
// nmi prescaled compare timer
`timescale 1ns/1ns

module nmi_timer #(
  parameter int TIM_W = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t rsp_o,
  output logic              irq_o
);

  logic             ready_q;
  logic             accept;
  logic             wr_en;
  logic [5:0]       idx;
  logic [31:0]      rd_val;
  logic [31:0]      wr_val;
  logic [1:0]       ctrl_q;
  logic [TIM_W-1:0] psc_q;
  logic [TIM_W-1:0] cmp_q;
  logic [TIM_W-1:0] cnt_q;
  logic [TIM_W-1:0] pre_q;
  logic             stat_q;
  logic             tick;
  logic             hit;
  logic             stat_clr;

  assign idx    = req_i.addr[7:2];
  assign accept = req_i.valid && !ready_q;
  assign wr_en  = accept && (req_i.wstrb != 4'b0000);

  always_comb begin
    case (idx)
      nmi_pkg::REG_TIM_CTRL: rd_val = 32'(ctrl_q);
      nmi_pkg::REG_TIM_PSC:  rd_val = 32'(psc_q);
      nmi_pkg::REG_TIM_CMP:  rd_val = 32'(cmp_q);
      nmi_pkg::REG_TIM_CNT:  rd_val = 32'(cnt_q);
      nmi_pkg::REG_TIM_STAT: rd_val = 32'(stat_q);
      default:               rd_val = '0;
    endcase
  end

  assign wr_val = nmi_pkg::strb_merge(rd_val, req_i.wdata, req_i.wstrb);

  // prescaler wrap gives one count tick
  assign tick = ctrl_q[0] && (pre_q >= psc_q);
  assign hit  = tick && (cnt_q == cmp_q);

  // write one to clear
  assign stat_clr = wr_en && idx == nmi_pkg::REG_TIM_STAT &&
                    req_i.wstrb[0] && req_i.wdata[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      ctrl_q  <= '0;
      psc_q   <= '0;
      cmp_q   <= '0;
      cnt_q   <= '0;
      pre_q   <= '0;
      stat_q  <= 1'b0;
    end else begin
      ready_q <= accept;
      if (wr_en && idx == nmi_pkg::REG_TIM_CTRL) begin
        ctrl_q <= wr_val[1:0];
      end
      if (wr_en && idx == nmi_pkg::REG_TIM_PSC) begin
        psc_q <= wr_val[TIM_W-1:0];
      end
      if (wr_en && idx == nmi_pkg::REG_TIM_CMP) begin
        cmp_q <= wr_val[TIM_W-1:0];
      end

      if (!ctrl_q[0] || tick) begin
        pre_q <= '0;
      end else begin
        pre_q <= pre_q + 1'b1;
      end

      // software write wins over counting
      if (wr_en && idx == nmi_pkg::REG_TIM_CNT) begin
        cnt_q <= wr_val[TIM_W-1:0];
      end else if (hit) begin
        cnt_q <= '0;
      end else if (tick) begin
        cnt_q <= cnt_q + 1'b1;
      end

      // a new event is not lost to a clear
      if (hit) begin
        stat_q <= 1'b1;
      end else if (stat_clr) begin
        stat_q <= 1'b0;
      end
    end
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = ready_q ? rd_val : '0;
  assign irq_o       = stat_q && ctrl_q[1];

endmodule

// ==== src/nmi_gpio.sv ====
// nmi gpio register block
`timescale 1ns/1ns

module nmi_gpio #(
  parameter int GPIO_W = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t rsp_o,
  input  logic [GPIO_W-1:0] gpio_in_i,
  output logic [GPIO_W-1:0] gpio_out_o,
  output logic [GPIO_W-1:0] gpio_oe_o
);

  logic              ready_q;
  logic              accept;
  logic              wr_en;
  logic [5:0]        idx;
  logic [31:0]       rd_val;
  logic [31:0]       wr_val;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] in_meta_q;
  logic [GPIO_W-1:0] in_sync_q;

  assign idx    = req_i.addr[7:2];
  // no repeat while valid is still high in the ready cycle
  assign accept = req_i.valid && !ready_q;
  assign wr_en  = accept && (req_i.wstrb != 4'b0000);

  always_comb begin
    case (idx)
      nmi_pkg::REG_GPIO_OUT: rd_val = 32'(out_q);
      nmi_pkg::REG_GPIO_OE:  rd_val = 32'(oe_q);
      nmi_pkg::REG_GPIO_IN:  rd_val = 32'(in_sync_q);
      default:               rd_val = '0;
    endcase
  end

  assign wr_val = nmi_pkg::strb_merge(rd_val, req_i.wdata, req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      out_q   <= '0;
      oe_q    <= '0;
    end else begin
      ready_q <= accept;
      if (wr_en && idx == nmi_pkg::REG_GPIO_OUT) begin
        out_q <= wr_val[GPIO_W-1:0];
      end
      if (wr_en && idx == nmi_pkg::REG_GPIO_OE) begin
        oe_q <= wr_val[GPIO_W-1:0];
      end
    end
  end

  // two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = ready_q ? rd_val : '0;
  assign gpio_out_o  = out_q;
  assign gpio_oe_o   = oe_q;

endmodule

// ==== src/nmi_addr_decode.sv ====
// nmi address decoder
`timescale 1ns/1ns

module nmi_addr_decode (
  input  nmi_pkg::nmi_req_t           req_i,
  output logic [nmi_pkg::NUM_SLV-1:0] sel_o,
  output logic                        miss_o
);

  logic       region_hit;
  logic [7:0] slot;

  assign region_hit = req_i.addr[31:28] == nmi_pkg::NATV_IP_START;
  assign slot       = req_i.addr[15:8];

  // one-hot select from region and slot fields
  always_comb begin
    sel_o = '0;
    if (region_hit) begin
      case (slot)
        nmi_pkg::SLOT_GPIO: begin
          sel_o[nmi_pkg::SEL_GPIO] = 1'b1;
        end
        nmi_pkg::SLOT_TIM0: begin
          sel_o[nmi_pkg::SEL_TIM0] = 1'b1;
        end
        nmi_pkg::SLOT_TIM1: begin
          sel_o[nmi_pkg::SEL_TIM1] = 1'b1;
        end
        nmi_pkg::SLOT_SYSCTRL: begin
          sel_o[nmi_pkg::SEL_SYSCTRL] = 1'b1;
        end
        default: begin
          sel_o = '0;
        end
      endcase
    end
  end

  // valid access that no peripheral claims
  assign miss_o = req_i.valid && (sel_o == '0);

endmodule

// ==== src/nmi_pkg.sv ====
// nmi peripheral bus definitions
package nmi_pkg;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } nmi_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } nmi_rsp_t;

  // region in addr[31:28], slot in addr[15:8]
  localparam logic [3:0] NATV_IP_START = 4'h1;
  localparam logic [7:0] SLOT_GPIO     = 8'h00;
  localparam logic [7:0] SLOT_TIM0     = 8'h01;
  localparam logic [7:0] SLOT_TIM1     = 8'h02;
  localparam logic [7:0] SLOT_SYSCTRL  = 8'h03;

  // select vector positions
  localparam int NUM_SLV     = 4;
  localparam int SEL_GPIO    = 0;
  localparam int SEL_TIM0    = 1;
  localparam int SEL_TIM1    = 2;
  localparam int SEL_SYSCTRL = 3;

  // word offsets from addr[7:2]
  localparam logic [5:0] REG_GPIO_OUT    = 6'd0;
  localparam logic [5:0] REG_GPIO_OE     = 6'd1;
  localparam logic [5:0] REG_GPIO_IN     = 6'd2;
  localparam logic [5:0] REG_TIM_CTRL    = 6'd0;
  localparam logic [5:0] REG_TIM_PSC     = 6'd1;
  localparam logic [5:0] REG_TIM_CMP     = 6'd2;
  localparam logic [5:0] REG_TIM_CNT     = 6'd3;
  localparam logic [5:0] REG_TIM_STAT    = 6'd4;
  localparam logic [5:0] REG_SYS_ID      = 6'd0;
  localparam logic [5:0] REG_SYS_SCRATCH = 6'd1;
  localparam logic [5:0] REG_SYS_CTRL    = 6'd2;

  localparam logic [31:0] SYS_ID = 32'h5243_0001;

  // byte lanes with strobe set take the new value
  function automatic logic [31:0] strb_merge(
    input logic [31:0] old_val,
    input logic [31:0] new_val,
    input logic [3:0]  strb
  );
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8+:8] = new_val[b*8+:8];
      end
    end
    return res;
  endfunction

endpackage
